//--- rtl/cam_params.svh
// capture parameters: active window, pixel FIFO depth and input register depth
`ifndef CAM_PARAMS_SVH
`define CAM_PARAMS_SVH

// kept pixels per line
`define CAM_H_ACTIVE 320

// kept lines per frame
`define CAM_V_ACTIVE 240

// pixel FIFO address width, 16 entries
`define CAM_FIFO_AW 4

// register stages on the camera inputs
// the capture latency depends on this value
`define CAM_SYNC_STAGES 2

`endif

//--- rtl/cam_bus_pkg.sv
// camera bus package: types for the byte-wide OV7670 sensor interface
package cam_bus_pkg;

    // one data byte from the sensor
    typedef logic [7:0] cam_byte_t;

    // one sampled pixel-clock cycle of the camera pins
    typedef struct packed {
        logic      vsync;  // high during the frame pulse
        logic      hsync;  // high while line bytes are valid
        cam_byte_t data;
    } cam_bus_t;

endpackage

//--- rtl/pixel_pkg.sv
// pixel package: pixel word, window counters and capture FSM states
package pixel_pkg;

    // RGB444 pixel, red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] rgb444_t;

    // pixel position within a line
    typedef logic [9:0] h_count_t;

    // line position within a frame
    typedef logic [8:0] v_count_t;

    // capture FSM
    typedef enum logic [1:0] {
        WAIT_CFG,  // sensor not configured yet
        WAIT_SOF,  // armed, waiting for vsync fall
        ACTIVE     // pairing bytes inside the frame
    } cap_state_e;

endpackage

//--- rtl/cam_capture.sv
// camera capture: sync edge detection, line and frame counting, byte pairing and crop
`timescale 1ns/1ps
`include "cam_params.svh"

module cam_capture (
    input  logic                  i_pclk,
    input  logic                  i_rstn,
    input  logic                  i_cfg_done,
    input  cam_bus_pkg::cam_bus_t i_cam,
    output logic                  o_wr,
    output pixel_pkg::rgb444_t    o_wdata,
    output logic                  o_sof
);
    import cam_bus_pkg::*;
    import pixel_pkg::*;

    localparam int LAST = `CAM_SYNC_STAGES - 1;

    cam_bus_t   sync_q [`CAM_SYNC_STAGES];  // input register chain
    cam_bus_t   cam_s;                      // last stage, all logic works on this
    logic       vsync_d;                    // edge compare register
    logic       hsync_d;
    logic       sof;
    logic       line_start;

    cap_state_e state;
    cap_state_e state_nxt;
    h_count_t   h_count;                    // completed pixels in this line
    v_count_t   v_count;                    // current line
    logic       second_byte;                // pairing phase
    logic [3:0] red_hold;                   // red nibble of the first byte
    logic       keep;

    assign cam_s      = sync_q[LAST];
    assign sof        = vsync_d & ~cam_s.vsync;   // vsync fall
    assign line_start = cam_s.hsync & ~hsync_d;   // hsync rise
    assign keep       = (h_count < `CAM_H_ACTIVE) && (v_count < `CAM_V_ACTIVE);

    // input registers and edge compare
    always_ff @(posedge i_pclk) begin
        if (!i_rstn) begin
            for (int i = 0; i < `CAM_SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
            vsync_d <= 1'b0;
            hsync_d <= 1'b0;
            o_sof   <= 1'b0;
        end else begin
            sync_q[0] <= i_cam;
            for (int i = 1; i < `CAM_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            vsync_d <= cam_s.vsync;
            hsync_d <= cam_s.hsync;
            o_sof   <= sof;                  // third stage, fixed latency
        end
    end

    // the vsync pulse heads every frame, so a high vsync means a new frame is coming
    always_comb begin
        state_nxt = state;
        case (state)
            WAIT_CFG: begin
                if (i_cfg_done && cam_s.vsync) begin
                    state_nxt = WAIT_SOF;    // configured, next frame is whole
                end
            end
            WAIT_SOF: begin
                if (sof) begin
                    state_nxt = ACTIVE;
                end
            end
            ACTIVE: begin
                if (cam_s.vsync) begin
                    state_nxt = WAIT_SOF;    // re-arm for the next frame
                end
            end
            default: begin
                state_nxt = WAIT_CFG;
            end
        endcase
    end

    // counters, pairing phase and write strobe
    always_ff @(posedge i_pclk) begin
        if (!i_rstn) begin
            state       <= WAIT_CFG;
            h_count     <= '0;
            v_count     <= '1;
            second_byte <= 1'b0;
            o_wr        <= 1'b0;
        end else begin
            state <= state_nxt;
            o_wr  <= 1'b0;
            if (state == WAIT_SOF && sof) begin
                h_count     <= '0;
                v_count     <= '1;           // first hsync rise wraps to line 0
                second_byte <= 1'b0;
            end else if (state == ACTIVE && cam_s.hsync) begin
                if (line_start) begin
                    h_count     <= '0;
                    v_count     <= v_count + 1'b1;
                    second_byte <= 1'b1;     // this byte is red
                end else if (second_byte) begin
                    o_wr        <= keep;     // crop
                    second_byte <= 1'b0;
                    if (h_count != '1) begin
                        h_count <= h_count + 1'b1;
                    end
                end else begin
                    second_byte <= 1'b1;
                end
            end
        end
    end

    // pixel assembly
    always_ff @(posedge i_pclk) begin
        if (cam_s.hsync && (line_start || !second_byte)) begin
            red_hold <= cam_s.data[3:0];
        end
        o_wdata <= {red_hold, cam_s.data};   // green and blue whole
    end

endmodule

//--- rtl/pixel_fifo.sv
// pixel FIFO: single-clock circular buffer with empty flag and sticky overflow
`timescale 1ns/1ps
`include "cam_params.svh"

module pixel_fifo (
    input  logic               i_pclk,
    input  logic               i_rstn,
    input  logic               i_wr,
    input  pixel_pkg::rgb444_t i_wdata,
    input  logic               i_rd,
    output pixel_pkg::rgb444_t o_rd_data,
    output logic               o_empty,
    output logic               o_overflow
);
    import pixel_pkg::*;

    localparam logic [`CAM_FIFO_AW:0] DEPTH = 1 << `CAM_FIFO_AW;

    rgb444_t                 mem [0:DEPTH-1];
    logic [`CAM_FIFO_AW-1:0] wr_ptr;
    logic [`CAM_FIFO_AW-1:0] rd_ptr;
    logic [`CAM_FIFO_AW:0]   count;      // occupancy
    logic                    full;
    logic                    do_rd;
    logic                    do_wr;

    assign full    = (count == DEPTH);
    assign o_empty = (count == '0);
    assign do_rd   = i_rd & ~o_empty;            // read on empty ignored
    assign do_wr   = i_wr & (~full | do_rd);     // full but popping still fits

    always_ff @(posedge i_pclk) begin
        if (!i_rstn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (i_wr && !do_wr) begin
                o_overflow <= 1'b1;      // held until reset
            end
        end
    end

    // storage and read port
    always_ff @(posedge i_pclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wdata;
        end
        if (do_rd) begin
            o_rd_data <= mem[rd_ptr];    // one cycle after the strobe
        end
    end

endmodule

//--- rtl/cam_capture_top.sv
// camera capture top: capture block feeding the pixel FIFO write port
`timescale 1ns/1ps

module cam_capture_top (
    input  logic                  i_pclk,
    input  logic                  i_rstn,
    input  logic                  i_cfg_done,
    input  cam_bus_pkg::cam_bus_t i_cam,
    input  logic                  i_rd,
    output pixel_pkg::rgb444_t    o_rd_data,
    output logic                  o_empty,
    output logic                  o_overflow,
    output logic                  o_sof
);
    import pixel_pkg::*;

    logic    cap_wr;     // write strobe into the FIFO
    rgb444_t cap_wdata;

    cam_capture u_cam_capture (
        .i_pclk     (i_pclk),
        .i_rstn     (i_rstn),
        .i_cfg_done (i_cfg_done),
        .i_cam      (i_cam),
        .o_wr       (cap_wr),
        .o_wdata    (cap_wdata),
        .o_sof      (o_sof)
    );

    pixel_fifo u_pixel_fifo (
        .i_pclk     (i_pclk),
        .i_rstn     (i_rstn),
        .i_wr       (cap_wr),
        .i_wdata    (cap_wdata),
        .i_rd       (i_rd),
        .o_rd_data  (o_rd_data),
        .o_empty    (o_empty),
        .o_overflow (o_overflow)
    );

endmodule

//--- verif/cam_capture_properties.sv
// capture properties: reset values, write gating, sof latency and sticky overflow
`timescale 1ns/1ps

module cam_capture_properties (
    input logic                  i_pclk,
    input logic                  i_rstn,
    input logic                  i_cfg_done,
    input cam_bus_pkg::cam_bus_t i_cam,
    input logic                  i_rd,
    input logic                  i_wr,
    input logic                  i_empty,
    input logic                  i_overflow,
    input logic                  i_sof,
    input pixel_pkg::cap_state_e i_state
);
    import pixel_pkg::*;

    int err_count = 0;  // failures so far, polled by the testbench

    a_reset_values: assert property (@(posedge i_pclk)
        !i_rstn |=> (i_empty && !i_wr && !i_sof && !i_overflow))
        else begin
            $error("outputs not at their reset values after a reset cycle");
            err_count++;
        end

    // unconfigured sensor, nothing may reach the FIFO
    a_no_wr_before_cfg: assert property (@(posedge i_pclk) disable iff (!i_rstn)
        !i_cfg_done |-> (!i_wr && i_empty && (i_state == WAIT_CFG)))
        else begin
            $error("capture armed or pixel written while the sensor is not configured");
            err_count++;
        end

    a_sof_latency: assert property (@(posedge i_pclk) disable iff (!i_rstn)
        $fell(i_cam.vsync) |-> ##3 i_sof ##1 !i_sof)
        else begin
            $error("sof not a single pulse three cycles after the vsync fall");
            err_count++;
        end

    a_sof_cause: assert property (@(posedge i_pclk) disable iff (!i_rstn)
        i_sof |-> ($past(i_cam.vsync, 4) && !$past(i_cam.vsync, 3)))
        else begin
            $error("sof pulse without a vsync fall three cycles before");
            err_count++;
        end

    a_wr_pairs: assert property (@(posedge i_pclk) disable iff (!i_rstn)
        i_wr |=> !i_wr)  // one pixel per two bytes
        else begin
            $error("write strobe on two cycles in a row");
            err_count++;
        end

    a_ovf_sticky: assert property (@(posedge i_pclk) disable iff (!i_rstn)
        i_overflow |=> i_overflow)
        else begin
            $error("overflow flag cleared without reset");
            err_count++;
        end

    a_ovf_cause: assert property (@(posedge i_pclk) disable iff (!i_rstn)
        $rose(i_overflow) |-> $past(i_wr && !i_rd))
        else begin
            $error("overflow set without a write into a full FIFO");
            err_count++;
        end

endmodule

bind cam_capture_top cam_capture_properties u_props (
    .i_pclk     (i_pclk),
    .i_rstn     (i_rstn),
    .i_cfg_done (i_cfg_done),
    .i_cam      (i_cam),
    .i_rd       (i_rd),
    .i_wr       (cap_wr),
    .i_empty    (o_empty),
    .i_overflow (o_overflow),
    .i_sof      (o_sof),
    .i_state    (u_cam_capture.state)
);

//--- verif/cam_capture_tb.sv
// camera capture testbench: camera frame model, FIFO reader and pixel scoreboard
`timescale 1ns/1ps
`include "cam_params.svh"

module cam_capture_tb;
    import cam_bus_pkg::*;
    import pixel_pkg::*;

    localparam int DEPTH      = 1 << `CAM_FIFO_AW;
    localparam int VS_CYC     = 3;   // vsync pulse length
    localparam int BLANK      = 10;  // blank cycles after vsync
    localparam int GAP        = 16;  // hsync low between lines
    localparam int LINE_CYC   = 2 * (`CAM_H_ACTIVE + 4) + GAP;
    localparam int FRAME_CYC  = VS_CYC + BLANK + (`CAM_V_ACTIVE + 2) * LINE_CYC;
    localparam int MAX_CYCLES = 3 * FRAME_CYC + 1000;

    logic        i_pclk = 1'b0;
    logic        i_rstn;
    logic        i_cfg_done;
    cam_bus_t    i_cam;
    logic        i_rd;
    rgb444_t     o_rd_data;
    logic        o_empty;
    logic        o_overflow;
    logic        o_sof;

    logic [31:0] lfsr = 32'he107_61a5;
    rgb444_t     exp_q [$];      // pixels the FIFO should hold now
    logic [3:0]  pipe_v;         // kept pixels still in the capture pipeline
    rgb444_t     pipe_d [4];
    logic        ovf_exp = 1'b0;
    logic        stall = 1'b0;   // reader held off
    int          reads = 0;
    int          cycles = 0;

    cam_capture_top i_dut (
        .i_pclk     (i_pclk),
        .i_rstn     (i_rstn),
        .i_cfg_done (i_cfg_done),
        .i_cam      (i_cam),
        .i_rd       (i_rd),
        .o_rd_data  (o_rd_data),
        .o_empty    (o_empty),
        .o_overflow (o_overflow),
        .o_sof      (o_sof)
    );

    always #50 i_pclk = ~i_pclk;

    always @(posedge i_pclk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    // Galois LFSR, taps 32,22,2,1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_byte(output cam_byte_t b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    // score the edge just passed, then drive the next camera cycle
    task automatic step_cycle(input logic vs, input logic hs, input cam_byte_t data,
                              input logic push, input rgb444_t pix);
        logic    rd_now;
        logic    wr_now;
        rgb444_t wr_pix;
        rgb444_t head;
        int      free;
        @(posedge i_pclk);
        #1;
        rd_now = i_rd;
        wr_now = pipe_v[0];
        wr_pix = pipe_d[0];
        pipe_v = pipe_v >> 1;
        for (int i = 0; i < 3; i++) begin
            pipe_d[i] = pipe_d[i+1];
        end
        free = DEPTH - exp_q.size();
        if (rd_now) begin
            assert (exp_q.size() != 0) else fail_run("read strobe with no pixel expected");
            head = exp_q.pop_front();
            reads++;
            assert (o_rd_data == head) else fail_run($sformatf(
                "mismatch o_rd_data: got 0x%03h expected 0x%03h", o_rd_data, head));
        end
        if (wr_now) begin
            if (free > 0 || rd_now) begin
                exp_q.push_back(wr_pix);
            end else begin
                ovf_exp = 1'b1;          // full and not popping, pixel lost
            end
        end
        assert (o_empty == (exp_q.size() == 0)) else fail_run($sformatf(
            "mismatch o_empty: got 0x%0h expected 0x%0h", o_empty, exp_q.size() == 0));
        assert (o_overflow == ovf_exp) else fail_run($sformatf(
            "mismatch o_overflow: got 0x%0h expected 0x%0h", o_overflow, ovf_exp));
        assert (i_dut.u_props.err_count == 0) else fail_run("a bound property failed");
        i_rd  = ~o_empty & ~stall;
        i_cam = {vs, hs, data};
        if (push) begin
            pipe_v[3] = 1'b1;            // reaches the FIFO four edges later
            pipe_d[3] = pix;
        end
    endtask

    task automatic send_frame(input logic keep_frame, input int stall_line);
        cam_byte_t b0;
        cam_byte_t b1;
        logic      kept;
        repeat (VS_CYC) step_cycle(1'b1, 1'b0, 8'h00, 1'b0, '0);
        repeat (BLANK) step_cycle(1'b0, 1'b0, 8'h00, 1'b0, '0);
        for (int ln = 0; ln < `CAM_V_ACTIVE + 2; ln++) begin
            stall = (ln == stall_line);
            for (int px = 0; px < `CAM_H_ACTIVE + 4; px++) begin
                random_byte(b0);
                random_byte(b1);
                kept = keep_frame && (px < `CAM_H_ACTIVE) && (ln < `CAM_V_ACTIVE);
                step_cycle(1'b0, 1'b1, b0, 1'b0, '0);
                step_cycle(1'b0, 1'b1, b1, kept, {b0[3:0], b1});  // red from low nibble
            end
            repeat (GAP) step_cycle(1'b0, 1'b0, 8'h00, 1'b0, '0);
        end
        stall = 1'b0;
    endtask

    task automatic drain_fifo();
        while (exp_q.size() != 0 || pipe_v != '0) begin
            step_cycle(1'b0, 1'b0, 8'h00, 1'b0, '0);
        end
    endtask

    initial begin
        i_rstn     = 1'b0;
        i_cfg_done = 1'b0;
        i_cam      = '0;
        i_rd       = 1'b0;
        pipe_v     = '0;
        repeat (4) step_cycle(1'b0, 1'b0, 8'h00, 1'b0, '0);
        i_rstn = 1'b1;
        send_frame(1'b0, -1);            // sensor not configured yet
        drain_fifo();
        assert (reads == 0) else fail_run("pixels read from a frame sent before configuration");
        i_cfg_done = 1'b1;
        send_frame(1'b1, -1);
        drain_fifo();
        assert (reads == `CAM_H_ACTIVE * `CAM_V_ACTIVE) else fail_run($sformatf(
            "mismatch reads: got 0x%0h expected 0x%0h", reads, `CAM_H_ACTIVE * `CAM_V_ACTIVE));
        send_frame(1'b1, 5);             // reader stalls for a whole line
        drain_fifo();
        assert (ovf_exp) else fail_run("stall window never overflowed the FIFO");
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+rtl
rtl/cam_bus_pkg.sv
rtl/pixel_pkg.sv
rtl/cam_capture.sv
rtl/pixel_fifo.sv
rtl/cam_capture_top.sv
verif/cam_capture_properties.sv
verif/cam_capture_tb.sv
